// File: logic/afifo_defs.svh
// size and threshold macros for the dual-clock FIFO that the package and the RTL include
`ifndef AFIFO_DEFS_SVH
`define AFIFO_DEFS_SVH

// ******************************
// storage geometry
// ******************************

// width of one stored word
`define AFIFO_DATA_W 8

// storage address width
// pointers carry one extra wrap bit
`define AFIFO_PTR_W 4

// number of words is always a power of two
`define AFIFO_DEPTH (1 << `AFIFO_PTR_W)

// ******************************
// almost flag thresholds
// ******************************

// almost-full rises this many words below full
`define AFIFO_AFULL_OFFSET 2

// almost-empty is active at or below this fill level
`define AFIFO_AEMPTY_OFFSET 2

`endif

// File: logic/afifo_pkg.sv
// shared FIFO types that the module headers import by wildcard
`default_nettype none

`include "afifo_defs.svh"

package afifo_pkg;

    // one stored word
    typedef logic [`AFIFO_DATA_W-1:0] data_t;

    // storage address without the wrap bit
    typedef logic [`AFIFO_PTR_W-1:0] addr_t;

    // binary or gray pointer
    // msb is the wrap bit that tells full apart from empty
    typedef logic [`AFIFO_PTR_W:0] ptr_t;

    // fill count 0 .. depth is one bit wider than an address
    // so a full FIFO reads back as its true depth
    typedef logic [`AFIFO_PTR_W:0] level_t;

endpackage

`default_nettype wire

// File: logic/afifo_ptr_sync.sv
// two-flop gray pointer synchronizer with binary decode that is instanced once per crossing
`timescale 1ns/1ns
`default_nettype none

module afifo_ptr_sync import afifo_pkg::*; (
    input  logic i_clk,
    input  logic i_rrstn,
    input  ptr_t i_gray,
    output ptr_t o_gray_sync,
    output ptr_t o_bin_sync
);

    localparam int PW = $bits(ptr_t);

    // first stage may go metastable
    // second stage is the one consumers see
    ptr_t sync_q1;
    ptr_t sync_q2;

    always_ff @(posedge i_clk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= i_gray;
            sync_q2 <= sync_q1;
        end
    end

    assign o_gray_sync = sync_q2;

    // gray to binary
    // each binary bit is the xor of all gray bits at and above it
    always_comb begin
        for (int i = 0; i < PW; i++) begin
            o_bin_sync[i] = ^(sync_q2 >> i);
        end
    end

endmodule

`default_nettype wire

// File: logic/afifo_wr_ctrl.sv
// write-domain FIFO control holding the write pointer, full flag, fill level and almost-full
`timescale 1ns/1ns
`default_nettype none

`include "afifo_defs.svh"

module afifo_wr_ctrl import afifo_pkg::*; (
    input  logic   i_wclk,
    input  logic   i_rrstn,
    input  logic   i_wr,
    input  ptr_t   i_rbin_sync,
    input  ptr_t   i_rgray_sync,
    output addr_t  o_waddr,
    output logic   o_wen,
    output ptr_t   o_wgray,
    output logic   o_wfull,
    output logic   o_walmostfull,
    output level_t o_wfill
);

    localparam int PW = `AFIFO_PTR_W;

    // fill level at which almost-full goes active
    localparam level_t AFULL_LEVEL = level_t'(`AFIFO_DEPTH - `AFIFO_AFULL_OFFSET);

    ptr_t   wbin;
    ptr_t   wbin_next;
    ptr_t   wgray_next;
    logic   wfull_val;
    level_t wfill_val;

    // ******************************
    // write pointer
    // ******************************

    // a write only counts while not full
    assign o_wen = i_wr && !o_wfull;

    assign wbin_next  = wbin + ptr_t'(o_wen);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    // storage address drops the wrap bit
    assign o_waddr = wbin[PW-1:0];

    always_ff @(posedge i_wclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            wbin    <= '0;
            o_wgray <= '0;
        end else begin
            wbin    <= wbin_next;
            o_wgray <= wgray_next;
        end
    end

    // ******************************
    // flags and fill
    // ******************************

    // full when the write pointer is one lap ahead of the read pointer
    // in gray code that means the top two bits differ and the rest match
    assign wfull_val = (wgray_next == {~i_rgray_sync[PW:PW-1], i_rgray_sync[PW-2:0]});

    // modulo 2*depth difference that overestimates because the read pointer is stale
    assign wfill_val = level_t'(wbin_next - i_rbin_sync);

    always_ff @(posedge i_wclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            o_wfull       <= 1'b0;
            o_wfill       <= '0;
            // empty after reset so not almost full
            o_walmostfull <= 1'b0;
        end else begin
            o_wfull       <= wfull_val;
            o_wfill       <= wfill_val;
            o_walmostfull <= (wfill_val >= AFULL_LEVEL);
        end
    end

endmodule

`default_nettype wire

// File: logic/afifo_ram.sv
// FIFO storage array that is written on the write clock and read without a clock
`timescale 1ns/1ns
`default_nettype none

`include "afifo_defs.svh"

module afifo_ram import afifo_pkg::*; (
    input  logic  i_wclk,
    input  logic  i_wen,
    input  addr_t i_waddr,
    input  data_t i_wdata,
    input  addr_t i_raddr,
    output data_t o_rdata
);

    // one payload word per address
    data_t mem [0:`AFIFO_DEPTH-1];

    // write port in the write domain
    // enable already carries the full check
    always_ff @(posedge i_wclk) begin
        if (i_wen) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // asynchronous read port
    // head word shows as soon as the read address points at it
    assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

// File: logic/afifo_rd_ctrl.sv
// read-domain FIFO control holding the read pointer, empty flag, fill level and almost-empty
`timescale 1ns/1ns
`default_nettype none

`include "afifo_defs.svh"

module afifo_rd_ctrl import afifo_pkg::*; (
    input  logic   i_rclk,
    input  logic   i_rrstn,
    input  logic   i_rd,
    input  ptr_t   i_wgray_sync,
    input  ptr_t   i_wbin_sync,
    output addr_t  o_raddr,
    output ptr_t   o_rgray,
    output logic   o_rempty,
    output logic   o_ralmostempty,
    output level_t o_rfill
);

    localparam int PW = `AFIFO_PTR_W;

    // fill level at or below which almost-empty is active
    localparam level_t AEMPTY_LEVEL = level_t'(`AFIFO_AEMPTY_OFFSET);

    ptr_t   rbin;
    ptr_t   rbin_next;
    ptr_t   rgray_next;
    logic   ren;
    logic   rempty_val;
    level_t rfill_val;

    // ******************************
    // read pointer
    // ******************************

    // a read only counts while not empty
    assign ren = i_rd && !o_rempty;

    assign rbin_next  = rbin + ptr_t'(ren);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    // current pointer addresses the head word
    assign o_raddr = rbin[PW-1:0];

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rbin    <= '0;
            o_rgray <= '0;
        end else begin
            rbin    <= rbin_next;
            o_rgray <= rgray_next;
        end
    end

    // ******************************
    // flags and fill
    // ******************************

    // empty when the read pointer catches the synced write pointer
    // write pointer lags so empty drops late but never rises late
    assign rempty_val = (rgray_next == i_wgray_sync);

    // modulo 2*depth difference that underestimates while a write is in flight
    assign rfill_val = level_t'(i_wbin_sync - rbin_next);

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            o_rempty       <= 1'b1;
            o_rfill        <= '0;
            o_ralmostempty <= 1'b1;
        end else begin
            o_rempty       <= rempty_val;
            o_rfill        <= rfill_val;
            o_ralmostempty <= (rfill_val <= AEMPTY_LEVEL);
        end
    end

endmodule

`default_nettype wire

// File: logic/afifo_top.sv
// dual-clock FIFO top level that connects both controllers, the synchronizers and storage
`timescale 1ns/1ns
`default_nettype none

module afifo_top import afifo_pkg::*; (
    // write domain
    input  logic   i_wclk,
    input  logic   i_rclk,
    input  logic   i_rrstn,
    input  logic   i_wr,
    input  data_t  i_wdata,
    output logic   o_wfull,
    output logic   o_walmostfull,
    output level_t o_wfill,
    // read domain
    input  logic   i_rd,
    output data_t  o_rdata,
    output logic   o_rempty,
    output logic   o_ralmostempty,
    output level_t o_rfill
);

    // write side nets
    addr_t waddr;
    logic  wen;
    ptr_t  wgray;
    ptr_t  rgray_sync;
    ptr_t  rbin_sync;

    // read side nets
    addr_t raddr;
    ptr_t  rgray;
    ptr_t  wgray_sync;
    ptr_t  wbin_sync;

    // ******************************
    // write domain
    // ******************************

    afifo_wr_ctrl i_afifo_wr_ctrl (
        .i_wclk        (i_wclk),
        .i_rrstn       (i_rrstn),
        .i_wr          (i_wr),
        .i_rbin_sync   (rbin_sync),
        .i_rgray_sync  (rgray_sync),
        .o_waddr       (waddr),
        .o_wen         (wen),
        .o_wgray       (wgray),
        .o_wfull       (o_wfull),
        .o_walmostfull (o_walmostfull),
        .o_wfill       (o_wfill)
    );

    // read pointer into the write clock
    afifo_ptr_sync i_afifo_ptr_sync_r2w (
        .i_clk       (i_wclk),
        .i_rrstn     (i_rrstn),
        .i_gray      (rgray),
        .o_gray_sync (rgray_sync),
        .o_bin_sync  (rbin_sync)
    );

    afifo_ram i_afifo_ram (
        .i_wclk  (i_wclk),
        .i_wen   (wen),
        .i_waddr (waddr),
        .i_wdata (i_wdata),
        .i_raddr (raddr),
        .o_rdata (o_rdata)
    );

    // ******************************
    // read domain
    // ******************************

    // write pointer into the read clock
    afifo_ptr_sync i_afifo_ptr_sync_w2r (
        .i_clk       (i_rclk),
        .i_rrstn     (i_rrstn),
        .i_gray      (wgray),
        .o_gray_sync (wgray_sync),
        .o_bin_sync  (wbin_sync)
    );

    afifo_rd_ctrl i_afifo_rd_ctrl (
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_rd           (i_rd),
        .i_wgray_sync   (wgray_sync),
        .i_wbin_sync    (wbin_sync),
        .o_raddr        (raddr),
        .o_rgray        (rgray),
        .o_rempty       (o_rempty),
        .o_ralmostempty (o_ralmostempty),
        .o_rfill        (o_rfill)
    );

endmodule

`default_nettype wire

// File: verif/afifo_assertions.sv
// concurrent flag and fill checks for the dual-clock FIFO that bind into the top level
`timescale 1ns/1ns
`default_nettype none

`include "afifo_defs.svh"

module afifo_assertions import afifo_pkg::*; (
    input logic   i_wclk,
    input logic   i_rclk,
    input logic   i_rrstn,
    input logic   i_wfull,
    input logic   i_walmostfull,
    input level_t i_wfill,
    input logic   i_rempty,
    input logic   i_ralmostempty,
    input level_t i_rfill
);

    localparam level_t DEPTH_LEVEL = level_t'(`AFIFO_DEPTH);

    // ******************************
    // flag pairs
    // ******************************

    wfull_has_almost: assert property (@(posedge i_wclk) disable iff (!i_rrstn)
        i_wfull |-> i_walmostfull) else $error("full without almost-full");

    rempty_has_almost: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        i_rempty |-> i_ralmostempty) else $error("empty without almost-empty");

    // ******************************
    // fill bounds
    // ******************************

    wfill_in_range: assert property (@(posedge i_wclk) disable iff (!i_rrstn)
        i_wfill <= DEPTH_LEVEL) else $error("write fill above depth");

    rfill_in_range: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        i_rfill <= DEPTH_LEVEL) else $error("read fill above depth");

    // a partly filled FIFO can not look full and empty at once
    no_full_and_empty: assert property (@(posedge i_wclk) disable iff (!i_rrstn)
        (i_wfill >= level_t'(1) && i_wfill <= DEPTH_LEVEL - level_t'(1))
        |-> !(i_wfull && i_rempty)) else $error("full and empty while partly filled");

endmodule

`default_nettype wire

// File: verif/afifo_tb.sv
// self-checking testbench top that runs a table of write and read bursts through the FIFO
`timescale 1ns/1ns
`default_nettype none

`include "afifo_defs.svh"

module afifo_tb import afifo_pkg::*; ();

    localparam int NUM_ROWS     = 9;
    localparam int SETTLE_LIMIT = 40;
    localparam int AFULL_LEVEL  = `AFIFO_DEPTH - `AFIFO_AFULL_OFFSET;

    // write attempts, read attempts, settle afterwards, expected words (-1 skips)
    typedef struct packed {
        int n_wr;
        int n_rd;
        bit settle;
        int exp_level;
    } row_t;

    logic        i_wclk;
    logic        i_rclk;
    logic        i_rrstn;
    logic        i_wr;
    data_t       i_wdata;
    logic        i_rd;
    logic        o_wfull;
    logic        o_walmostfull;
    level_t      o_wfill;
    data_t       o_rdata;
    logic        o_rempty;
    logic        o_ralmostempty;
    level_t      o_rfill;

    row_t        rows [0:NUM_ROWS-1];
    data_t       ref_q [$];
    logic [31:0] lfsr;

    afifo_top i_afifo_top (
        .i_wclk         (i_wclk),
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_wr           (i_wr),
        .i_wdata        (i_wdata),
        .o_wfull        (o_wfull),
        .o_walmostfull  (o_walmostfull),
        .o_wfill        (o_wfill),
        .i_rd           (i_rd),
        .o_rdata        (o_rdata),
        .o_rempty       (o_rempty),
        .o_ralmostempty (o_ralmostempty),
        .o_rfill        (o_rfill)
    );

    bind afifo_top afifo_assertions i_afifo_assertions (
        .i_wclk         (i_wclk),
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_wfull        (o_wfull),
        .i_walmostfull  (o_walmostfull),
        .i_wfill        (o_wfill),
        .i_rempty       (o_rempty),
        .i_ralmostempty (o_ralmostempty),
        .i_rfill        (o_rfill)
    );

    // ******************************
    // write clock 20 ns and read clock 34 ns
    // ******************************

    always #10 i_wclk = ~i_wclk;
    always #17 i_rclk = ~i_rclk;

    // right-shift galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one lfsr step per data bit
    task automatic make_word(output data_t w);
        for (int b = 0; b < `AFIFO_DATA_W; b++) begin
            lfsr = lfsr_step(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_val(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // ******************************
    // stimulus table
    // ******************************

    task automatic load_table();
        rows[0] = '{20,  0, 1'b1, 16};
        rows[1] = '{ 0, 16, 1'b1,  0};
        rows[2] = '{ 9,  4, 1'b1, -1};
        rows[3] = '{ 7, 12, 1'b0, -1};
        rows[4] = '{12,  5, 1'b1, -1};
        rows[5] = '{ 0, 30, 1'b1,  0};
        rows[6] = '{ 1,  0, 1'b1,  1};
        rows[7] = '{30, 30, 1'b1, -1};
        rows[8] = '{ 0, 40, 1'b1,  0};
    endtask

    task automatic write_burst(input int count);
        data_t w;
        for (int k = 0; k < count; k++) begin
            make_word(w);
            @(posedge i_wclk);
            i_wr    <= 1'b1;
            i_wdata <= w;
            // full holds through the low phase so the next edge sees this value
            @(negedge i_wclk);
            if (!o_wfull) begin
                ref_q.push_back(w);
            end
        end
        @(posedge i_wclk);
        i_wr <= 1'b0;
    endtask

    task automatic read_burst(input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge i_rclk);
            i_rd <= 1'b1;
            @(negedge i_rclk);
            if (!o_rempty) begin
                assert (ref_q.size() > 0) else begin
                    $display("ERROR at %0t: FIFO offers data that was never written", $time);
                    abort_run();
                end
                // fall-through data is the head word before the read edge
                check_val("o_rdata", int'(ref_q[0]), int'(o_rdata));
                void'(ref_q.pop_front());
            end else begin
                check_val("o_rfill", 0, int'(o_rfill));
            end
        end
        @(posedge i_rclk);
        i_rd <= 1'b0;
    endtask

    // wait until both domains have seen the last pointer moves
    task automatic settle_and_check(input int exp_level);
        int n;
        int tries;
        n = ref_q.size();
        tries = 0;
        do begin
            @(negedge i_wclk);
            tries++;
        end while ((int'(o_wfill) != n || int'(o_rfill) != n) && tries < SETTLE_LIMIT);
        assert (int'(o_wfill) == n && int'(o_rfill) == n) else begin
            $display("ERROR at %0t: fill levels did not settle at %0d words (wfill %0d rfill %0d)",
                     $time, n, o_wfill, o_rfill);
            abort_run();
        end
        if (exp_level >= 0) begin
            check_val("words held", exp_level, n);
        end
        check_val("o_wfull", int'(n == `AFIFO_DEPTH), int'(o_wfull));
        check_val("o_rempty", int'(n == 0), int'(o_rempty));
        check_val("o_walmostfull", int'(n >= AFULL_LEVEL), int'(o_walmostfull));
        check_val("o_ralmostempty", int'(n <= `AFIFO_AEMPTY_OFFSET), int'(o_ralmostempty));
    endtask

    task automatic check_reset();
        check_val("o_wfull", 0, int'(o_wfull));
        check_val("o_walmostfull", 0, int'(o_walmostfull));
        check_val("o_wfill", 0, int'(o_wfill));
        check_val("o_rfill", 0, int'(o_rfill));
        check_val("o_rempty", 1, int'(o_rempty));
        check_val("o_ralmostempty", 1, int'(o_ralmostempty));
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin
        i_wclk  = 1'b0;
        i_rclk  = 1'b0;
        i_rrstn = 1'b0;
        i_wr    = 1'b0;
        i_wdata = '0;
        i_rd    = 1'b0;
        lfsr    = 32'h10d0_bfcd;
        load_table();
        repeat (3) @(posedge i_wclk);
        i_rrstn <= 1'b1;
        @(negedge i_wclk);
        check_reset();
        for (int r = 0; r < NUM_ROWS; r++) begin
            // both domains run at once
            fork
                write_burst(rows[r].n_wr);
                read_burst(rows[r].n_rd);
            join
            if (rows[r].settle) begin
                settle_and_check(rows[r].exp_level);
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/afifo_pkg.sv
logic/afifo_ptr_sync.sv
logic/afifo_wr_ctrl.sv
logic/afifo_ram.sv
logic/afifo_rd_ctrl.sv
logic/afifo_top.sv
verif/afifo_assertions.sv
verif/afifo_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= afifo_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
